// ==== files.f ====
priv_pkg.sv
priv_internal_if.sv
priv_csr_rfile.sv
priv_trap_ctrl.sv
priv_block.sv
priv_checker.sv
tb_priv_block.sv

// ==== priv_block.sv ====
// Machine-mode privilege unit top level
// Joins the CSR file and the trap controller and exposes
// the pipeline CSR port, trap inputs and the fetch redirect
`timescale 1ns/10ps
`default_nettype none

module priv_block import priv_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  csr_op_t   csr_op,
  input  csr_addr_t csr_addr,
  input  word_t     wdata,
  input  logic      instr_retired,
  input  logic      ex_illegal,
  input  logic      ex_ecall,
  input  logic      ex_break,
  input  word_t     epc,
  input  word_t     tval,
  input  logic      mret,
  input  logic      ext_int,
  input  logic      timer_int,
  input  logic      soft_int,
  output word_t     rdata,
  output logic      invalid_csr,
  output logic      insert_pc,
  output word_t     priv_pc
);

  priv_internal_if prv_if ();

  // Pipeline CSR request goes straight to the register file
  assign prv_if.csr_op   = csr_op;
  assign prv_if.csr_addr = csr_addr;
  assign prv_if.wdata    = wdata;
  assign rdata           = prv_if.rdata;
  assign invalid_csr     = prv_if.invalid_csr;

  priv_csr_rfile priv_csr_rfile_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .instr_retired (instr_retired),
    .prv_if        (prv_if.csr)
  );

  priv_trap_ctrl priv_trap_ctrl_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .ex_illegal (ex_illegal),
    .ex_ecall   (ex_ecall),
    .ex_break   (ex_break),
    .mret       (mret),
    .ext_int    (ext_int),
    .timer_int  (timer_int),
    .soft_int   (soft_int),
    .epc        (epc),
    .tval       (tval),
    .insert_pc  (insert_pc),
    .priv_pc    (priv_pc),
    .prv_if     (prv_if.trap)
  );

endmodule

`default_nettype wire

// ==== priv_checker.sv ====
// Assertion checker for the privilege unit
// Watches the trap redirect and the CSR error flag
`timescale 1ns/10ps
`default_nettype none

module priv_checker import priv_pkg::*; (
  input logic    CLK,
  input logic    nRST,
  input csr_op_t csr_op,
  input logic    invalid_csr,
  input logic    insert_pc,
  input logic    mret,
  input logic    mstatus_mie
);

  // Failed assertions, read by the testbench at the end of the run
  int fail_count = 0;

  // No redirect while the unit is held in reset
  redirect_in_reset: assert property (@(posedge CLK) !nRST |-> !insert_pc)
    else begin
      fail_count++;
      $error("insert_pc high while nRST is low");
    end

  // A trap clears the global interrupt enable
  mie_cleared_by_trap: assert property (
    @(posedge CLK) disable iff (!nRST) (insert_pc && !mret) |=> !mstatus_mie)
    else begin
      fail_count++;
      $error("mstatus.mie still set in the cycle after a trap");
    end

  // The error flag needs a real request
  invalid_needs_request: assert property (
    @(posedge CLK) disable iff (!nRST) (csr_op == CSR_NONE) |-> !invalid_csr)
    else begin
      fail_count++;
      $error("invalid_csr high without a CSR request");
    end

endmodule

// The top level sees both the trap redirect and the CSR error flag
bind priv_block priv_checker checker_i (
  .CLK         (CLK),
  .nRST        (nRST),
  .csr_op      (csr_op),
  .invalid_csr (invalid_csr),
  .insert_pc   (insert_pc),
  .mret        (mret),
  .mstatus_mie (prv_if.mstatus.mie)
);

`default_nettype wire

// ==== priv_csr_rfile.sv ====
// Machine-mode CSR register file
// Serves pipeline reads and swap/set/clear writes by address,
// merges trap controller updates and runs the cycle and retire counters
`timescale 1ns/10ps
`default_nettype none

module priv_csr_rfile import priv_pkg::*; (
  input logic          CLK,
  input logic          nRST,
  input logic          instr_retired,
  priv_internal_if.csr prv_if
);

  // Only the two enable bits of mstatus hold state
  logic     mstatus_mie, mstatus_mie_d;
  logic     mstatus_mpie, mstatus_mpie_d;
  mstatus_t mstatus_init;
  mstatus_t mstatus_view;
  mstatus_t rup_mstatus;

  mie_t        mie_q, mie_d;
  mip_t        mip_q, mip_d;
  mtvec_t      mtvec_q, mtvec_d;
  word_t       mscratch_q, mscratch_d;
  word_t       mepc_q, mepc_d;
  mcause_t     mcause_q, mcause_d;
  word_t       mtval_q, mtval_d;
  logic [63:0] mcycle;
  logic [63:0] minstret;

  logic  valid_addr;
  logic  wr_en;
  word_t rup_data;

  assign mstatus_init = mstatus_t'(MSTATUS_RESET);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_mie  <= mstatus_init.mie;
      mstatus_mpie <= mstatus_init.mpie;
      mie_q        <= '0;
      mip_q        <= '0;
      mtvec_q      <= '0;
      mscratch_q   <= '0;
      mepc_q       <= '0;
      mcause_q     <= '0;
      mtval_q      <= '0;
      mcycle       <= '0;
      minstret     <= '0;
    end else begin
      mstatus_mie  <= mstatus_mie_d;
      mstatus_mpie <= mstatus_mpie_d;
      mie_q        <= mie_d;
      mip_q        <= mip_d;
      mtvec_q      <= mtvec_d;
      mscratch_q   <= mscratch_d;
      mepc_q       <= mepc_d;
      mcause_q     <= mcause_d;
      mtval_q      <= mtval_d;
      mcycle       <= mcycle + 64'd1;
      minstret     <= minstret + {63'd0, instr_retired};
    end
  end

  // mpp always reads as machine level
  always_comb begin
    mstatus_view      = '0;
    mstatus_view.mpp  = MPP_MACHINE;
    mstatus_view.mpie = mstatus_mpie;
    mstatus_view.mie  = mstatus_mie;
  end

  // Read-modify-write value against the current register contents
  assign wr_en = (prv_if.csr_op != CSR_NONE) && valid_addr;

  always_comb begin
    case (prv_if.csr_op)
      CSR_RW:  rup_data = prv_if.wdata;
      CSR_RS:  rup_data = prv_if.rdata | prv_if.wdata;
      CSR_RC:  rup_data = prv_if.rdata & ~prv_if.wdata;
      default: rup_data = prv_if.rdata;
    endcase
  end

  assign rup_mstatus = mstatus_t'(rup_data);

  // Pipeline writes win over a hardware update in the same cycle
  always_comb begin
    mstatus_mie_d  = mstatus_mie;
    mstatus_mpie_d = mstatus_mpie;
    if (wr_en && prv_if.csr_addr == MSTATUS) begin
      mstatus_mie_d  = rup_mstatus.mie;
      mstatus_mpie_d = rup_mstatus.mpie;
    end else if (prv_if.mstatus_rup) begin
      mstatus_mie_d  = prv_if.mstatus_next.mie;
      mstatus_mpie_d = prv_if.mstatus_next.mpie;
    end
  end

  always_comb begin
    mepc_d = mepc_q;
    if (wr_en && prv_if.csr_addr == MEPC) begin
      mepc_d = rup_data;
    end else if (prv_if.mepc_rup) begin
      mepc_d = prv_if.mepc_next;
    end
  end

  always_comb begin
    mtval_d = mtval_q;
    if (wr_en && prv_if.csr_addr == MTVAL) begin
      mtval_d = rup_data;
    end else if (prv_if.mtval_rup) begin
      mtval_d = prv_if.mtval_next;
    end
  end

  // Written by software only
  assign mie_d = (wr_en && prv_if.csr_addr == MIE) ?
                 mie_t'(rup_data & IRQ_MASK) : mie_q;
  assign mtvec_d = (wr_en && prv_if.csr_addr == MTVEC) ? mtvec_t'(rup_data) : mtvec_q;
  assign mscratch_d = (wr_en && prv_if.csr_addr == MSCRATCH) ? rup_data : mscratch_q;

  // Written by hardware only
  assign mcause_d = prv_if.mcause_rup ? prv_if.mcause_next : mcause_q;
  assign mip_d    = prv_if.mip_rup ? mip_t'(prv_if.mip_next & IRQ_MASK) : mip_q;

  always_comb begin
    valid_addr   = 1'b1;
    prv_if.rdata = '0;
    case (prv_if.csr_addr)
      MVENDORID, MARCHID, MIMPID, MHARTID: prv_if.rdata = '0;
      MISA:      prv_if.rdata = MISA_VALUE;
      MSTATUS:   prv_if.rdata = mstatus_view;
      MIE:       prv_if.rdata = mie_q;
      MTVEC:     prv_if.rdata = mtvec_q;
      MSCRATCH:  prv_if.rdata = mscratch_q;
      MEPC:      prv_if.rdata = mepc_q;
      MCAUSE:    prv_if.rdata = mcause_q;
      MTVAL:     prv_if.rdata = mtval_q;
      MIP:       prv_if.rdata = mip_q;
      MCYCLE:    prv_if.rdata = mcycle[31:0];
      MCYCLEH:   prv_if.rdata = mcycle[63:32];
      MINSTRET:  prv_if.rdata = minstret[31:0];
      MINSTRETH: prv_if.rdata = minstret[63:32];
      default:   valid_addr = 1'b0;
    endcase
  end

  assign prv_if.invalid_csr = (prv_if.csr_op != CSR_NONE) && !valid_addr;

  assign prv_if.mstatus = mstatus_view;
  assign prv_if.mie     = mie_q;
  assign prv_if.mip     = mip_q;
  assign prv_if.mtvec   = mtvec_q;
  assign prv_if.mepc    = mepc_q;

endmodule

`default_nettype wire

// ==== priv_internal_if.sv ====
// Link between the machine CSR file and the trap controller
// Carries pipeline CSR requests, hardware update strobes
// and the live register values seen by the trap logic
`timescale 1ns/10ps
`default_nettype none

interface priv_internal_if import priv_pkg::*; ();

  // Pipeline CSR request and response
  csr_op_t   csr_op;
  csr_addr_t csr_addr;
  word_t     wdata;
  word_t     rdata;
  logic      invalid_csr;

  // Hardware updates from the trap controller
  mstatus_t  mstatus_next;
  word_t     mepc_next;
  mcause_t   mcause_next;
  word_t     mtval_next;
  mip_t      mip_next;
  logic      mstatus_rup;
  logic      mepc_rup;
  logic      mcause_rup;
  logic      mtval_rup;
  logic      mip_rup;

  // Current register values
  mstatus_t  mstatus;
  mie_t      mie;
  mip_t      mip;
  mtvec_t    mtvec;
  word_t     mepc;

  modport csr (
    input  csr_op, csr_addr, wdata,
    input  mstatus_next, mepc_next, mcause_next, mtval_next, mip_next,
    input  mstatus_rup, mepc_rup, mcause_rup, mtval_rup, mip_rup,
    output rdata, invalid_csr,
    output mstatus, mie, mip, mtvec, mepc
  );

  modport trap (
    output mstatus_next, mepc_next, mcause_next, mtval_next, mip_next,
    output mstatus_rup, mepc_rup, mcause_rup, mtval_rup, mip_rup,
    input  mstatus, mie, mip, mtvec, mepc
  );

endinterface

`default_nettype wire

// ==== priv_pkg.sv ====
// Machine-mode privilege definitions for a small RV32I core
// CSR addresses and operations, trap causes, register layouts
// and the reset constants shared by the privilege unit
`default_nettype none

package priv_pkg;

  typedef logic [31:0] word_t;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_t;

  // Implemented machine CSR addresses
  typedef enum logic [11:0] {
    MSTATUS   = 12'h300,
    MISA      = 12'h301,
    MIE       = 12'h304,
    MTVEC     = 12'h305,
    MSCRATCH  = 12'h340,
    MEPC      = 12'h341,
    MCAUSE    = 12'h342,
    MTVAL     = 12'h343,
    MIP       = 12'h344,
    MCYCLE    = 12'hB00,
    MINSTRET  = 12'hB02,
    MCYCLEH   = 12'hB80,
    MINSTRETH = 12'hB82,
    MVENDORID = 12'hF11,
    MARCHID   = 12'hF12,
    MIMPID    = 12'hF13,
    MHARTID   = 12'hF14
  } csr_addr_t;

  // Interrupt causes carry bit 31, so each value is a complete mcause word
  typedef enum logic [31:0] {
    ILLEGAL_INSN = 32'h0000_0002,
    BREAKPOINT   = 32'h0000_0003,
    ECALL_M      = 32'h0000_000B,
    SOFT_INT_M   = 32'h8000_0003,
    TIMER_INT_M  = 32'h8000_0007,
    EXT_INT_M    = 32'h8000_000B
  } cause_code_t;

  typedef struct packed {
    logic [18:0] reserved_3;
    logic [1:0]  mpp;
    logic [2:0]  reserved_2;
    logic        mpie;
    logic [2:0]  reserved_1;
    logic        mie;
    logic [2:0]  reserved_0;
  } mstatus_t;

  typedef struct packed {
    logic [19:0] reserved_3;
    logic        meie;
    logic [2:0]  reserved_2;
    logic        mtie;
    logic [2:0]  reserved_1;
    logic        msie;
    logic [2:0]  reserved_0;
  } mie_t;

  typedef struct packed {
    logic [19:0] reserved_3;
    logic        meip;
    logic [2:0]  reserved_2;
    logic        mtip;
    logic [2:0]  reserved_1;
    logic        msip;
    logic [2:0]  reserved_0;
  } mip_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvec_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  // RV32 with the I extension only
  localparam word_t MISA_VALUE    = 32'h4000_0100;
  localparam word_t MSTATUS_RESET = 32'h0000_1800;
  // Machine software, timer and external bits of mie and mip
  localparam word_t IRQ_MASK      = 32'h0000_0888;
  localparam logic [1:0] MPP_MACHINE    = 2'b11;
  localparam logic [1:0] MTVEC_VECTORED = 2'b01;

endpackage

`default_nettype wire

// ==== priv_trap_ctrl.sv ====
// Machine-mode trap controller
// Samples the interrupt pins into mip, picks the highest priority trap,
// drives trap entry and mret state updates and the redirect PC
`timescale 1ns/10ps
`default_nettype none

module priv_trap_ctrl import priv_pkg::*; (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          ex_illegal,
  input  logic          ex_ecall,
  input  logic          ex_break,
  input  logic          mret,
  input  logic          ext_int,
  input  logic          timer_int,
  input  logic          soft_int,
  input  word_t         epc,
  input  word_t         tval,
  output logic          insert_pc,
  output word_t         priv_pc,
  priv_internal_if.trap prv_if
);

  mip_t        irq_sample;
  mip_t        pending;
  logic        int_req, exc_req, trap;
  cause_code_t int_cause, exc_cause, cause;
  mcause_t     trap_cause;
  mstatus_t    status_d;
  word_t       trap_base;

  // Pin levels load mip at every edge, so mip trails the pins by one cycle
  always_comb begin
    irq_sample      = '0;
    irq_sample.meip = ext_int;
    irq_sample.mtip = timer_int;
    irq_sample.msip = soft_int;
  end

  assign prv_if.mip_next = irq_sample;
  assign prv_if.mip_rup  = 1'b1;

  assign pending = mip_t'(prv_if.mip & prv_if.mie);

  // External, then software, then timer
  always_comb begin
    int_req   = 1'b0;
    int_cause = SOFT_INT_M;
    if (prv_if.mstatus.mie) begin
      if (pending.meip) begin
        int_req   = 1'b1;
        int_cause = EXT_INT_M;
      end else if (pending.msip) begin
        int_req   = 1'b1;
        int_cause = SOFT_INT_M;
      end else if (pending.mtip) begin
        int_req   = 1'b1;
        int_cause = TIMER_INT_M;
      end
    end
  end

  assign exc_req = ex_break | ex_ecall | ex_illegal;

  always_comb begin
    if (ex_break) begin
      exc_cause = BREAKPOINT;
    end else if (ex_ecall) begin
      exc_cause = ECALL_M;
    end else begin
      exc_cause = ILLEGAL_INSN;
    end
  end

  // Interrupts win over exceptions
  assign trap       = int_req | exc_req;
  assign cause      = int_req ? int_cause : exc_cause;
  assign trap_cause = mcause_t'(cause);

  assign prv_if.mepc_rup    = trap;
  assign prv_if.mepc_next   = epc;
  assign prv_if.mcause_rup  = trap;
  assign prv_if.mcause_next = trap_cause;
  assign prv_if.mtval_rup   = trap;
  assign prv_if.mtval_next  = (cause == ILLEGAL_INSN) ? tval : '0;

  // Interrupt enable stack, trap entry takes priority over mret
  always_comb begin
    status_d = prv_if.mstatus;
    if (trap) begin
      status_d.mpie = prv_if.mstatus.mie;
      status_d.mie  = 1'b0;
    end else if (mret) begin
      status_d.mie  = prv_if.mstatus.mpie;
      status_d.mpie = 1'b1;
    end
  end

  assign prv_if.mstatus_next = status_d;
  assign prv_if.mstatus_rup  = trap | mret;

  assign trap_base = {prv_if.mtvec.base, 2'b00};

  always_comb begin
    if (trap) begin
      priv_pc = trap_base;
      if (int_req && prv_if.mtvec.mode == MTVEC_VECTORED) begin
        priv_pc = trap_base + {trap_cause.code[29:0], 2'b00};
      end
    end else begin
      priv_pc = prv_if.mepc;
    end
  end

  assign insert_pc = trap | mret;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the privilege unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_priv_block
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_priv_block)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

// ==== tb_priv_block.sv ====
// Directed testbench for the machine-mode privilege unit
// Covers reset values, CSR operations, exceptions, interrupts, mret and counters
`timescale 1ns/10ps
`default_nettype none

module tb_priv_block import priv_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int QUARTER     = CLK_PERIOD / 4;
  localparam int TEST_CYCLES = 200;
  localparam int TIMEOUT_NS  = 5 * TEST_CYCLES * CLK_PERIOD;

  // Expected register images
  localparam word_t EXP_MISA         = 32'h4000_0100;
  localparam word_t EXP_MSTATUS      = 32'h0000_1800;
  localparam word_t MSTATUS_ENABLE   = 32'h0000_0008;
  localparam word_t MSTATUS_TRAPPED  = 32'h0000_1880;
  localparam word_t MSTATUS_RESTORED = 32'h0000_1888;
  localparam word_t IRQ_BITS         = 32'h0000_0888;
  localparam logic [11:0] UNUSED_ADDR = 12'h7C0;

  logic      CLK;
  logic      nRST;
  csr_op_t   csr_op;
  csr_addr_t csr_addr;
  word_t     wdata, epc, tval, rdata, priv_pc;
  logic      instr_retired, ex_illegal, ex_ecall, ex_break, mret;
  logic      ext_int, timer_int, soft_int, invalid_csr, insert_pc;

  int     errors;
  integer seed;
  word_t  trap_vector;
  word_t  vec_base;

  priv_block priv_block_i (
    .CLK (CLK), .nRST (nRST), .csr_op (csr_op), .csr_addr (csr_addr), .wdata (wdata),
    .instr_retired (instr_retired), .ex_illegal (ex_illegal), .ex_ecall (ex_ecall),
    .ex_break (ex_break), .epc (epc), .tval (tval), .mret (mret), .ext_int (ext_int),
    .timer_int (timer_int), .soft_int (soft_int), .rdata (rdata),
    .invalid_csr (invalid_csr), .insert_pc (insert_pc), .priv_pc (priv_pc)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_word(input string name, input word_t exp, input word_t got);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_cause(input string name, input mcause_t exp, input mcause_t got);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s expected interrupt=%b code=%0d, got interrupt=%b code=%0d",
               $time, name, exp.interrupt, exp.code, got.interrupt, got.code);
    end
  endtask

  function automatic mcause_t expected_cause(input logic intr, input int code);
    mcause_t c;
    c.interrupt = intr;
    c.code      = 31'(code);
    return c;
  endfunction

  // One request cycle, returns the old value seen before the edge
  task automatic csr_access(input csr_op_t op, input csr_addr_t addr, input word_t data,
                            output word_t old, output logic inv);
    @(negedge CLK);
    csr_op   = op;
    csr_addr = addr;
    wdata    = data;
    #(QUARTER);
    old = rdata;
    inv = invalid_csr;
    @(negedge CLK);
    csr_op = CSR_NONE;
  endtask

  task automatic read_csr(input csr_addr_t addr, output word_t data);
    @(negedge CLK);
    csr_op   = CSR_NONE;
    csr_addr = addr;
    #(QUARTER);
    data = rdata;
  endtask

  task automatic write_csr(input csr_addr_t addr, input word_t data);
    word_t old;
    logic  inv;
    csr_access(CSR_RW, addr, data, old, inv);
    check_bit("invalid_csr on write", 1'b0, inv);
  endtask

  task automatic expect_csr(input string name, input csr_addr_t addr, input word_t exp);
    word_t got;
    read_csr(addr, got);
    check_word(name, exp, got);
  endtask

  task automatic test_reset_values();
    word_t old;
    logic  inv;
    #(QUARTER);
    check_bit("insert_pc after reset", 1'b0, insert_pc);
    check_bit("invalid_csr after reset", 1'b0, invalid_csr);
    expect_csr("mstatus", MSTATUS, EXP_MSTATUS);
    expect_csr("misa", MISA, EXP_MISA);
    expect_csr("mtvec", MTVEC, 32'h0);
    expect_csr("mepc", MEPC, 32'h0);
    expect_csr("mie", MIE, 32'h0);
    csr_access(CSR_RW, csr_addr_t'(UNUSED_ADDR), $random(seed), old, inv);
    check_bit("invalid_csr for unused address", 1'b1, inv);
    expect_csr("mscratch after invalid write", MSCRATCH, 32'h0);
    expect_csr("mstatus after invalid write", MSTATUS, EXP_MSTATUS);
  endtask

  // Swap, set and clear against a model that starts from the reset value
  task automatic rmw_sequence(input string name, input csr_addr_t addr, input word_t mask);
    word_t model, data, old;
    logic  inv;
    model = 32'h0;
    data  = $random(seed);
    csr_access(CSR_RW, addr, data, old, inv);
    check_word({name, " before RW"}, model, old);
    model = data & mask;
    data  = $random(seed);
    csr_access(CSR_RS, addr, data, old, inv);
    check_word({name, " before RS"}, model, old);
    model = (model | data) & mask;
    data  = $random(seed);
    csr_access(CSR_RC, addr, data, old, inv);
    check_word({name, " before RC"}, model, old);
    model = model & ~data;
    expect_csr({name, " after RC"}, addr, model);
  endtask

  task automatic test_csr_ops();
    rmw_sequence("mscratch", MSCRATCH, 32'hFFFF_FFFF);
    rmw_sequence("mtvec", MTVEC, 32'hFFFF_FFFF);
    rmw_sequence("mie", MIE, IRQ_BITS);
    write_csr(MVENDORID, $random(seed));
    expect_csr("mvendorid after write", MVENDORID, 32'h0);
    write_csr(MISA, $random(seed));
    expect_csr("misa after write", MISA, EXP_MISA);
    write_csr(MIE, 32'h0);
  endtask

  task automatic take_exception(input logic brk, input logic ecall, input logic ill,
                                input int code, input string name, output word_t pc);
    word_t val;
    write_csr(MSTATUS, MSTATUS_ENABLE);
    pc  = $random(seed) & ~32'h3;
    val = $random(seed);
    @(negedge CLK);
    ex_break   = brk;
    ex_ecall   = ecall;
    ex_illegal = ill;
    epc        = pc;
    tval       = val;
    #(QUARTER);
    check_bit({name, " insert_pc"}, 1'b1, insert_pc);
    check_word({name, " priv_pc"}, trap_vector & ~32'h3, priv_pc);
    @(negedge CLK);
    {ex_break, ex_ecall, ex_illegal} = 3'b000;
    expect_csr({name, " mepc"}, MEPC, pc);
    read_csr(MCAUSE, val);
    check_cause({name, " mcause"}, expected_cause(1'b0, code), mcause_t'(val));
    expect_csr({name, " mtval"}, MTVAL, (code == 2) ? tval : 32'h0);
    expect_csr({name, " mstatus"}, MSTATUS, MSTATUS_TRAPPED);
  endtask

  task automatic test_exceptions();
    word_t pc;
    trap_vector = $random(seed) & ~32'h3;
    write_csr(MTVEC, trap_vector);
    take_exception(1'b0, 1'b1, 1'b0, 11, "ecall", pc);
    take_exception(1'b1, 1'b0, 1'b0, 3, "break", pc);
    take_exception(1'b0, 1'b0, 1'b1, 2, "illegal", pc);
    take_exception(1'b1, 1'b1, 1'b0, 3, "break+ecall", pc);
    take_exception(1'b0, 1'b1, 1'b1, 11, "ecall+illegal", pc);
    take_exception(1'b1, 1'b0, 1'b1, 3, "break+illegal", pc);
  endtask

  task automatic hold_pins_masked(input string name);
    @(negedge CLK);
    {ext_int, timer_int, soft_int} = 3'b111;
    repeat (5) begin
      @(negedge CLK);
      #(QUARTER);
      check_bit(name, 1'b0, insert_pc);
    end
    @(negedge CLK);
    {ext_int, timer_int, soft_int} = 3'b000;
    repeat (3) @(negedge CLK);
  endtask

  // Pins are {ext, timer, soft}; the trap is due once mip has sampled the pin
  task automatic take_interrupt(input logic [2:0] pins, input int code, input string name);
    word_t pc, val;
    pc = $random(seed) & ~32'h3;
    @(negedge CLK);
    {ext_int, timer_int, soft_int} = pins;
    epc = pc;
    #(QUARTER);
    check_bit({name, " insert_pc early"}, 1'b0, insert_pc);
    @(negedge CLK);
    #(QUARTER);
    check_bit({name, " insert_pc"}, 1'b1, insert_pc);
    check_word({name, " priv_pc"}, vec_base + word_t'(4 * code), priv_pc);
    @(negedge CLK);
    #(QUARTER);
    check_bit({name, " second trap"}, 1'b0, insert_pc);
    @(negedge CLK);
    {ext_int, timer_int, soft_int} = 3'b000;
    repeat (2) @(negedge CLK);
    read_csr(MCAUSE, val);
    check_cause({name, " mcause"}, expected_cause(1'b1, code), mcause_t'(val));
    expect_csr({name, " mepc"}, MEPC, pc);
    expect_csr({name, " mstatus"}, MSTATUS, MSTATUS_TRAPPED);
    write_csr(MSTATUS, MSTATUS_ENABLE);
  endtask

  task automatic test_interrupts();
    vec_base = $random(seed) & ~32'h3;
    write_csr(MTVEC, vec_base | 32'h1);
    write_csr(MSTATUS, 32'h0);
    write_csr(MIE, IRQ_BITS);
    hold_pins_masked("insert_pc with mstatus.mie clear");
    write_csr(MIE, 32'h0);
    write_csr(MSTATUS, MSTATUS_ENABLE);
    hold_pins_masked("insert_pc with mie bits clear");
    write_csr(MIE, IRQ_BITS);
    take_interrupt(3'b100, 11, "external");
    take_interrupt(3'b001, 3, "software");
    take_interrupt(3'b010, 7, "timer");
    take_interrupt(3'b111, 11, "all pins");
  endtask

  task automatic test_mret();
    word_t pc;
    write_csr(MTVEC, trap_vector);
    take_exception(1'b0, 1'b1, 1'b0, 11, "ecall before mret", pc);
    @(negedge CLK);
    mret = 1'b1;
    #(QUARTER);
    check_bit("mret insert_pc", 1'b1, insert_pc);
    check_word("mret priv_pc", pc, priv_pc);
    @(negedge CLK);
    mret = 1'b0;
    expect_csr("mstatus after mret", MSTATUS, MSTATUS_RESTORED);
  endtask

  task automatic test_counters();
    word_t first, last;
    int    pulses;
    pulses = 4 + ($random(seed) & 7);
    read_csr(MINSTRET, first);
    repeat (pulses) begin
      @(negedge CLK);
      instr_retired = 1'b1;
      @(negedge CLK);
      instr_retired = 1'b0;
    end
    expect_csr("minstret", MINSTRET, first + word_t'(pulses));
    read_csr(MCYCLE, first);
    repeat (12) @(negedge CLK);
    read_csr(MCYCLE, last);
    check_word("mcycle difference", 32'd13, last - first);
  endtask

  initial begin
    errors   = 0;
    seed     = 32'h913c_4622;
    nRST     = 1'b0;
    csr_op   = CSR_NONE;
    csr_addr = MSTATUS;
    wdata    = '0;
    epc      = '0;
    tval     = '0;
    {instr_retired, ex_illegal, ex_ecall, ex_break, mret} = 5'b00000;
    {ext_int, timer_int, soft_int} = 3'b000;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    test_reset_values();
    test_csr_ops();
    test_exceptions();
    test_interrupts();
    test_mret();
    test_counters();

    $display("Done with %0d check errors and %0d assertion failures",
             errors, priv_block_i.checker_i.fail_count);
    if (errors == 0 && priv_block_i.checker_i.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
